// File: hdl/tcp_conn_slot.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_conn_slot
  import tcp_srv_pkg::*;
#(
  parameter int   SLOT_ID  = 0,
  parameter seq_t ISS_BASE = 32'h1000_0000
) (
  input  wire logic tcp_cts_srv,
  input  wire logic rst,
  input  slot_cfg_t cfg,
  input  wire logic sel,
  input  seg_t      seg,
  output slot_stat_t stat,
  output logic      rep_valid,
  output seg_t      rep,
  input  wire logic rep_take
);

  // initial sequence number of this slot
  localparam seq_t ISS = ISS_BASE + seq_t'(SLOT_ID) * 32'h0100_0000;

  conn_state_e state_q;
  ipv4_t       rem_ipv4_q;
  port_t       rem_port_q;
  logic        rep_valid_q;
  seg_t        rep_q;

  logic        seg_act;
  logic        abort;
  logic        syn_hit;
  logic        ack_hit;
  logic        fin_hit;

  ////////////////////
  // segment decode
  ////////////////////

  assign seg_act = sel && cfg.en;
  assign abort   = seg_act && seg.flags[FLAG_RST];

  assign syn_hit = seg_act && !abort && (state_q == st_listen) && seg.flags[FLAG_SYN];
  assign ack_hit = seg_act && !abort && (state_q == st_syn_rcvd) &&
                   seg.flags[FLAG_ACK] && (seg.ack == ISS + 32'd1);
  assign fin_hit = seg_act && !abort && (state_q == st_established) &&
                   seg.flags[FLAG_FIN];

  ////////////////////
  // state machine
  ////////////////////

  always_ff @(posedge tcp_cts_srv) begin
    if (rst) begin
      state_q     <= st_listen;
      rep_valid_q <= 1'b0;
    end else begin
      if (rep_take) begin
        rep_valid_q <= 1'b0;
      end
      if (syn_hit || fin_hit) begin
        rep_valid_q <= 1'b1;
      end

      // disabling the slot drops the connection
      if (!cfg.en || abort || fin_hit) begin
        state_q <= st_listen;
      end else if (syn_hit) begin
        state_q <= st_syn_rcvd;
      end else if (ack_hit) begin
        state_q <= st_established;
      end
    end
  end

  // remote endpoint and reply header
  always_ff @(posedge tcp_cts_srv) begin
    if (syn_hit) begin
      rem_ipv4_q <= seg.rem_ipv4;
      rem_port_q <= seg.rem_port;
    end
    if (syn_hit || fin_hit) begin
      rep_q.rem_ipv4 <= seg.rem_ipv4;
      rep_q.rem_port <= seg.rem_port;
      rep_q.loc_port <= cfg.port;
      rep_q.ack      <= seg.seq + 32'd1;
      rep_q.seq      <= syn_hit ? ISS : ISS + 32'd1;
      rep_q.flags    <= '0;
      rep_q.flags[FLAG_ACK] <= 1'b1;
      rep_q.flags[FLAG_SYN] <= syn_hit;
      rep_q.flags[FLAG_FIN] <= fin_hit;
    end
  end

  assign rep_valid = rep_valid_q;
  assign rep       = rep_q;

  assign stat.state    = state_q;
  assign stat.rem_ipv4 = rem_ipv4_q;
  assign stat.rem_port = rem_port_q;
  assign stat.busy     = rep_valid_q;

  // reply must sit still until the arbiter takes it
  a_rep_hold : assert property (
    @(posedge tcp_cts_srv) disable iff (rst)
    (rep_valid && !rep_take) |=> (rep_valid && $stable(rep))
  );

endmodule

`default_nettype wire

// File: hdl/tcp_reply_arb.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_reply_arb
  import tcp_srv_pkg::*;
#(
  parameter int N_SLOT = 4
) (
  input  wire logic               tcp_cts_srv,
  input  wire logic               rst,
  input  wire logic [N_SLOT-1:0]  rep_valid,
  input  seg_t [N_SLOT-1:0]       rep,
  output logic [N_SLOT-1:0]       rep_take,
  output seg_t                    rep_out,
  output logic                    rep_out_valid,
  input  wire logic               rep_out_ready
);

  localparam int IW = (N_SLOT > 1) ? $clog2(N_SLOT) : 1;

  logic [IW-1:0] last_q;
  logic [IW-1:0] grant_idx;
  logic          found;
  logic          can_load;
  logic          out_valid_q;
  seg_t          out_q;

  // output register free or draining this cycle
  assign can_load = !out_valid_q || rep_out_ready;

  // round robin, lowest pending index above the last grant
  always_comb begin
    int j;
    found     = 1'b0;
    grant_idx = last_q;
    for (int k = N_SLOT; k >= 1; k--) begin
      j = (int'(last_q) + k) % N_SLOT;
      if (rep_valid[j]) begin
        found     = 1'b1;
        grant_idx = IW'(j);
      end
    end
  end

  always_comb begin
    rep_take = '0;
    if (found && can_load) begin
      rep_take[grant_idx] = 1'b1;
    end
  end

  always_ff @(posedge tcp_cts_srv) begin
    if (rst) begin
      out_valid_q <= 1'b0;
      last_q      <= IW'(N_SLOT - 1);
    end else if (can_load) begin
      out_valid_q <= found;
      if (found) begin
        last_q <= grant_idx;
      end
    end
  end

  always_ff @(posedge tcp_cts_srv) begin
    if (can_load && found) begin
      out_q <= rep[grant_idx];
    end
  end

  assign rep_out       = out_q;
  assign rep_out_valid = out_valid_q;

  a_take_onehot : assert property (
    @(posedge tcp_cts_srv) disable iff (rst)
    $onehot0(rep_take)
  );

endmodule

`default_nettype wire

// File: hdl/tcp_seg_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_seg_dispatch
  import tcp_srv_pkg::*;
#(
  parameter int N_SLOT = 4
) (
  input  wire logic                    tcp_cts_srv,
  input  wire logic                    rst,
  input  seg_t                         seg_in,
  input  wire logic                    seg_valid,
  output logic                         seg_ready,
  input  slot_cfg_t [N_SLOT-1:0]       cfg,
  input  slot_stat_t [N_SLOT-1:0]      stat,
  output logic [N_SLOT-1:0]            slot_sel,
  output seg_t                         seg_fwd
);

  logic [N_SLOT-1:0] conn_match;
  logic [N_SLOT-1:0] lsn_match;
  logic [N_SLOT-1:0] busy_vec;
  logic [N_SLOT-1:0] conn_pick;
  logic [N_SLOT-1:0] lsn_pick;
  logic [N_SLOT-1:0] pick;
  logic              is_open;

  // a fresh SYN without ACK may claim a listening slot
  assign is_open = seg_in.flags[FLAG_SYN] && !seg_in.flags[FLAG_ACK];

  always_comb begin
    for (int i = 0; i < N_SLOT; i++) begin
      conn_match[i] = cfg[i].en && (cfg[i].port == seg_in.loc_port) &&
                      (stat[i].state != st_listen) &&
                      (stat[i].rem_ipv4 == seg_in.rem_ipv4) &&
                      (stat[i].rem_port == seg_in.rem_port);
      lsn_match[i]  = cfg[i].en && (cfg[i].port == seg_in.loc_port) &&
                      (stat[i].state == st_listen);
      busy_vec[i]   = stat[i].busy;
    end
  end

  // isolate lowest set bit of each candidate vector
  assign conn_pick = conn_match & (~conn_match + 1'b1);
  assign lsn_pick  = lsn_match & (~lsn_match + 1'b1);

  always_comb begin
    if (|conn_pick) begin
      pick = conn_pick;
    end else if (is_open) begin
      pick = lsn_pick;
    end else begin
      // nothing matches, segment gets dropped
      pick = '0;
    end
  end

  // stall only when the chosen slot still holds a reply
  assign seg_ready = ~|(pick & busy_vec);
  assign slot_sel  = (seg_valid && seg_ready) ? pick : '0;
  assign seg_fwd   = seg_in;

  a_sel_onehot : assert property (
    @(posedge tcp_cts_srv) disable iff (rst)
    $onehot0(slot_sel)
  );

endmodule

`default_nettype wire

// File: hdl/tcp_srv_pkg.sv
`default_nettype none

package tcp_srv_pkg;

  ////////////////////
  // field widths
  ////////////////////

  typedef logic [31:0] ipv4_t;
  typedef logic [15:0] port_t;
  typedef logic [31:0] seq_t;
  typedef logic [4:0]  tcp_flags_t;

  // flag bit positions inside tcp_flags_t
  localparam int FLAG_FIN = 0;
  localparam int FLAG_SYN = 1;
  localparam int FLAG_RST = 2;
  localparam int FLAG_PSH = 3;
  localparam int FLAG_ACK = 4;

  ////////////////////
  // segment header
  ////////////////////

  // rem_* is the source on input, the destination on a reply
  typedef struct packed {
    ipv4_t      rem_ipv4;
    port_t      rem_port;
    port_t      loc_port;
    seq_t       seq;
    seq_t       ack;
    tcp_flags_t flags;
  } seg_t;

  ////////////////////
  // slot state
  ////////////////////

  typedef enum logic [1:0] {
    st_listen      = 2'd0,
    st_syn_rcvd    = 2'd1,
    st_established = 2'd2
  } conn_state_e;

  // host side configuration of one slot
  typedef struct packed {
    port_t port;
    logic  en;
  } slot_cfg_t;

  // what a slot reports back
  typedef struct packed {
    conn_state_e state;
    ipv4_t       rem_ipv4;
    port_t       rem_port;
    logic        busy;
  } slot_stat_t;

endpackage

`default_nettype wire

// File: hdl/tcp_srv_top.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_srv_top
  import tcp_srv_pkg::*;
#(
  parameter int   N_SLOT   = 4,
  parameter seq_t ISS_BASE = 32'h1000_0000
) (
  input  wire logic        tcp_cts_srv,
  input  wire logic        rst,
  input  seg_t             seg_in,
  input  wire logic        seg_valid,
  output logic             seg_ready,
  output seg_t             rep_out,
  output logic             rep_out_valid,
  input  wire logic        rep_out_ready,
  input  wire logic        wb_cyc,
  input  wire logic        wb_stb,
  input  wire logic        wb_we,
  input  wire logic [2:0]  wb_adr,
  input  wire logic [31:0] wb_dat_w,
  output logic [31:0]      wb_dat_r,
  output logic             wb_ack
);

  slot_cfg_t [N_SLOT-1:0]  cfg;
  slot_stat_t [N_SLOT-1:0] stat;
  logic [N_SLOT-1:0]       slot_sel;
  seg_t                    seg_fwd;
  logic [N_SLOT-1:0]       rep_valid;
  logic [N_SLOT-1:0]       rep_take;
  seg_t [N_SLOT-1:0]       rep;

  tcp_wb_regs #(
    .N_SLOT (N_SLOT)
  ) u_regs (
    .tcp_cts_srv (tcp_cts_srv),
    .rst         (rst),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .cfg         (cfg),
    .stat        (stat)
  );

  tcp_seg_dispatch #(
    .N_SLOT (N_SLOT)
  ) u_dispatch (
    .tcp_cts_srv (tcp_cts_srv),
    .rst         (rst),
    .seg_in      (seg_in),
    .seg_valid   (seg_valid),
    .seg_ready   (seg_ready),
    .cfg         (cfg),
    .stat        (stat),
    .slot_sel    (slot_sel),
    .seg_fwd     (seg_fwd)
  );

  ////////////////////
  // connection slots
  ////////////////////

  for (genvar i = 0; i < N_SLOT; i++) begin : g_slot
    tcp_conn_slot #(
      .SLOT_ID  (i),
      .ISS_BASE (ISS_BASE)
    ) u_slot (
      .tcp_cts_srv (tcp_cts_srv),
      .rst         (rst),
      .cfg         (cfg[i]),
      .sel         (slot_sel[i]),
      .seg         (seg_fwd),
      .stat        (stat[i]),
      .rep_valid   (rep_valid[i]),
      .rep         (rep[i]),
      .rep_take    (rep_take[i])
    );
  end

  tcp_reply_arb #(
    .N_SLOT (N_SLOT)
  ) u_arb (
    .tcp_cts_srv   (tcp_cts_srv),
    .rst           (rst),
    .rep_valid     (rep_valid),
    .rep           (rep),
    .rep_take      (rep_take),
    .rep_out       (rep_out),
    .rep_out_valid (rep_out_valid),
    .rep_out_ready (rep_out_ready)
  );

endmodule

`default_nettype wire

// File: hdl/tcp_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_wb_regs
  import tcp_srv_pkg::*;
#(
  parameter int N_SLOT = 4
) (
  input  wire logic               tcp_cts_srv,
  input  wire logic               rst,
  input  wire logic               wb_cyc,
  input  wire logic               wb_stb,
  input  wire logic               wb_we,
  input  wire logic [2:0]         wb_adr,
  input  wire logic [31:0]        wb_dat_w,
  output logic [31:0]             wb_dat_r,
  output logic                    wb_ack,
  output slot_cfg_t [N_SLOT-1:0]  cfg,
  input  slot_stat_t [N_SLOT-1:0] stat
);

  localparam logic [2:0] ADR_STATUS = 3'd4;

  slot_cfg_t [N_SLOT-1:0] cfg_q;
  logic                   ack_q;
  logic                   done_q;
  logic                   req;
  logic                   cfg_hit;
  logic [31:0]            status;
  logic [31:0]            rd_data;

  // new request, not yet answered
  assign req     = wb_cyc && wb_stb && !ack_q && !done_q;
  assign cfg_hit = int'(wb_adr) < N_SLOT;

  ////////////////////
  // status word
  ////////////////////

  always_comb begin
    status = '0;
    for (int i = 0; i < N_SLOT; i++) begin
      status[i]     = (stat[i].state == st_established);
      status[8 + i] = (stat[i].state == st_syn_rcvd);
    end
  end

  always_comb begin
    rd_data = '0;
    if (cfg_hit) begin
      rd_data[15:0] = cfg_q[wb_adr].port;
      rd_data[16]   = cfg_q[wb_adr].en;
    end else if (wb_adr == ADR_STATUS) begin
      rd_data = status;
    end
  end

  always_ff @(posedge tcp_cts_srv) begin
    if (rst) begin
      cfg_q  <= '0;
      ack_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      ack_q <= req;
      // hold off a second ack until the cycle ends
      if (!(wb_cyc && wb_stb)) begin
        done_q <= 1'b0;
      end else if (req) begin
        done_q <= 1'b1;
      end
      if (req && wb_we && cfg_hit) begin
        cfg_q[wb_adr].port <= wb_dat_w[15:0];
        cfg_q[wb_adr].en   <= wb_dat_w[16];
      end
    end
  end

  always_ff @(posedge tcp_cts_srv) begin
    if (req) begin
      wb_dat_r <= rd_data;
    end
  end

  assign wb_ack = ack_q;
  assign cfg    = cfg_q;

  a_ack_in_cycle : assert property (
    @(posedge tcp_cts_srv) disable iff (rst)
    wb_ack |-> (wb_cyc && wb_stb)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the tcp_srv testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tcp_srv_tb -f tcp_srv.f -o tcp_srv_sim

# run the simulation and keep its output in sim.log
./obj_dir/tcp_srv_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// File: tcp_srv.f
hdl/tcp_srv_pkg.sv
hdl/tcp_seg_dispatch.sv
hdl/tcp_conn_slot.sv
hdl/tcp_reply_arb.sv
hdl/tcp_wb_regs.sv
hdl/tcp_srv_top.sv
verif/tcp_srv_tb.sv

// File: verif/tcp_srv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_srv_tb
  import tcp_srv_pkg::*;
();

  localparam string TEST_FILE    = "verif/tcp_srv_tests.txt";
  localparam int    REPLY_WAIT   = 2;
  localparam int    QUIET_CYCLES = 8;
  localparam int    STALL_LIMIT  = 32;
  localparam int    ACK_LIMIT    = 8;

  logic        tcp_cts_srv;
  logic        rst;
  seg_t        seg_in;
  logic        seg_valid;
  logic        seg_ready;
  seg_t        rep_out;
  logic        rep_out_valid;
  logic        rep_out_ready;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  int cycles;
  int cycle_limit;

  tcp_srv_top #(
    .N_SLOT   (4),
    .ISS_BASE (32'h1000_0000)
  ) dut (
    .tcp_cts_srv   (tcp_cts_srv),
    .rst           (rst),
    .seg_in        (seg_in),
    .seg_valid     (seg_valid),
    .seg_ready     (seg_ready),
    .rep_out       (rep_out),
    .rep_out_valid (rep_out_valid),
    .rep_out_ready (rep_out_ready),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack)
  );

  always #2 tcp_cts_srv = ~tcp_cts_srv;

  // run length limit from the size of the test file
  always @(posedge tcp_cts_srv) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the test run did not finish", cycles);
      stop_on_error();
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  task automatic stop_on_error();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got === exp) else begin
      $display("FAIL at %0t ns: %s expected %h, actual %h", $time, name, exp, got);
      stop_on_error();
    end
  endtask

  // one classic cycle held until wb_ack
  task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdata);
    int n;
    n = 0;
    @(posedge tcp_cts_srv);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    do begin
      @(negedge tcp_cts_srv);
      n++;
      if (n > ACK_LIMIT) begin
        $display("no wb_ack on the host port within %0d cycles", ACK_LIMIT);
        stop_on_error();
      end
    end while (!wb_ack);
    rdata = wb_dat_r;
    @(posedge tcp_cts_srv);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic send_seg(input seg_t s);
    int n;
    n = 0;
    @(posedge tcp_cts_srv);
    seg_in    <= s;
    seg_valid <= 1'b1;
    do begin
      @(negedge tcp_cts_srv);
      n++;
      if (n > STALL_LIMIT) begin
        $display("seg_ready stayed low for %0d cycles, segment never accepted", STALL_LIMIT);
        stop_on_error();
      end
    end while (!seg_ready);
    @(posedge tcp_cts_srv);
    seg_valid <= 1'b0;
  endtask

  task automatic expect_reply(input seg_t s);
    int n;
    n = 0;
    do begin
      @(negedge tcp_cts_srv);
      n++;
      if (!rep_out_ready) begin
        $display("a reply is expected while back-pressure is still on");
        stop_on_error();
      end
      if (!rep_out_valid && n >= REPLY_WAIT) begin
        $display("expected reply did not appear within %0d cycles", REPLY_WAIT);
        stop_on_error();
      end
    end while (!rep_out_valid);
    check_value("rep_out.rem_ipv4", s.rem_ipv4, rep_out.rem_ipv4);
    check_value("rep_out.rem_port", s.rem_port, rep_out.rem_port);
    check_value("rep_out.loc_port", s.loc_port, rep_out.loc_port);
    check_value("rep_out.seq", s.seq, rep_out.seq);
    check_value("rep_out.ack", s.ack, rep_out.ack);
    check_value("rep_out.flags", s.flags, rep_out.flags);
  endtask

  task automatic expect_quiet();
    repeat (QUIET_CYCLES) begin
      @(negedge tcp_cts_srv);
      check_value("rep_out_valid", 32'd0, rep_out_valid);
    end
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    int               fd;
    int               code;
    int               n_lines;
    logic [7:0]       cmd;
    logic [8*256-1:0] line;
    logic [31:0]      f_a;
    logic [31:0]      f_b;
    logic [31:0]      f_ip;
    logic [31:0]      f_rp;
    logic [31:0]      f_lp;
    logic [31:0]      f_sq;
    logic [31:0]      f_ak;
    logic [31:0]      f_fl;
    logic [31:0]      rdata;
    seg_t             s;

    tcp_cts_srv   = 1'b0;
    rst           = 1'b1;
    seg_in        = '0;
    seg_valid     = 1'b0;
    rep_out_ready = 1'b1;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    cycles        = 0;
    cycle_limit   = 0;

    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the test file %s", TEST_FILE);
      stop_on_error();
    end
    n_lines = 0;
    while (!$feof(fd)) begin
      if ($fgets(line, fd) > 0) begin
        n_lines++;
      end
    end
    $fclose(fd);
    // 64 cycles per line plus the reset
    cycle_limit = 64 * n_lines + 16;
    fd = $fopen(TEST_FILE, "r");

    repeat (16) @(posedge tcp_cts_srv);
    rst <= 1'b0;
    @(negedge tcp_cts_srv);
    check_value("seg_ready", 32'd1, seg_ready);
    check_value("rep_out_valid", 32'd0, rep_out_valid);
    check_value("wb_ack", 32'd0, wb_ack);

    while ($fscanf(fd, " %c", cmd) == 1) begin
      case (cmd)
        "#": code = $fgets(line, fd);
        "W": begin
          code = $fscanf(fd, "%h %h", f_a, f_b);
          wb_access(1'b1, f_a[2:0], f_b, rdata);
        end
        "R": begin
          code = $fscanf(fd, "%h %h", f_a, f_b);
          wb_access(1'b0, f_a[2:0], 32'd0, rdata);
          check_value("wb_dat_r", f_b, rdata);
        end
        "S", "E": begin
          code = $fscanf(fd, "%h %h %h %h %h %h", f_ip, f_rp, f_lp, f_sq, f_ak, f_fl);
          s.rem_ipv4 = f_ip;
          s.rem_port = f_rp[15:0];
          s.loc_port = f_lp[15:0];
          s.seq      = f_sq;
          s.ack      = f_ak;
          s.flags    = f_fl[4:0];
          if (cmd == "S") begin
            send_seg(s);
          end else begin
            expect_reply(s);
          end
        end
        "Q": expect_quiet();
        "B": begin
          code = $fscanf(fd, "%h", f_a);
          @(posedge tcp_cts_srv);
          rep_out_ready <= !f_a[0];
        end
        default: begin
          $display("unknown command '%c' in the test file", cmd);
          stop_on_error();
        end
      endcase
    end
    $fclose(fd);

    @(posedge tcp_cts_srv);
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/tcp_srv_tests.txt
# command letter then hex fields
# W adr data | R adr expected | S seg or E reply as rem_ipv4 rem_port loc_port seq ack flags
# Q expects 8 quiet cycles | B 1 holds off rep_out_ready and B 0 releases it
R 4 00000000
W 0 00010050
W 1 00010050
W 2 00011f90
W 3 00000016
R 0 00010050
R 1 00010050
R 2 00011f90
R 3 00000016
# no reply for a disabled slot or an unknown port or an ACK to a listening slot
S c0a80001 d431 0016 00000100 00000000 02
Q
S c0a80001 d431 1234 00000100 00000000 02
Q
S c0a80001 d431 0050 00000100 00000000 10
Q
R 4 00000000
# client A opens slot 0 and a wrong ACK is ignored
S c0a80001 d431 0050 00000100 00000000 02
E c0a80001 d431 0050 10000000 00000101 12
R 4 00000100
S c0a80001 d431 0050 00000101 10000005 10
Q
R 4 00000100
S c0a80001 d431 0050 00000101 10000001 10
Q
R 4 00000001
# client B on the same port lands in slot 1
S c0a80002 e001 0050 00002000 00000000 02
E c0a80002 e001 0050 11000000 00002001 12
S c0a80002 e001 0050 00002001 11000001 10
Q
R 4 00000003
# FIN closes slot 0 and RST drops slot 1
S c0a80001 d431 0050 00000101 10000001 11
E c0a80001 d431 0050 10000001 00000102 11
R 4 00000002
S c0a80002 e001 0050 00002001 00000000 04
Q
R 4 00000000
# three SYNs under back-pressure with slot 2 first
B 1
S c0a80005 3333 1f90 00005000 00000000 02
S c0a80003 1111 0050 00003000 00000000 02
S c0a80004 2222 0050 00004000 00000000 02
R 4 00000700
B 0
E c0a80005 3333 1f90 12000000 00005001 12
E c0a80003 1111 0050 10000000 00003001 12
E c0a80004 2222 0050 11000000 00004001 12
Q
